// File: design/mecobo_bus_pkg.sv
// host bus and command bus definitions
// data and address types, command word layout,
// EBI word address map, unit numbers and command FIFO depth
`default_nettype none

package mecobo_bus_pkg;

    typedef logic [15:0] ebi_word_t;
    typedef logic [18:0] ebi_addr_t;
    typedef logic [31:0] timestamp_t;
    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;
    typedef logic [7:0]  unit_t;

    // timestamp, command address, command data from msb down
    typedef logic [79:0] command_t;

    localparam int CMD_TS_LSB   = 48;
    localparam int CMD_ADDR_LSB = 32;

    // staging words, most significant first
    localparam ebi_addr_t EBI_CMD_W0       = 19'd0;
    localparam ebi_addr_t EBI_CMD_W1       = 19'd1;
    localparam ebi_addr_t EBI_CMD_W2       = 19'd2;
    localparam ebi_addr_t EBI_CMD_W3       = 19'd3;
    localparam ebi_addr_t EBI_CMD_W4       = 19'd4;
    localparam ebi_addr_t EBI_CTRL         = 19'd5;
    localparam ebi_addr_t EBI_STATUS       = 19'd6;
    localparam ebi_addr_t EBI_SAMPLE       = 19'd7;
    localparam ebi_addr_t EBI_SAMPLE_COUNT = 19'd8;
    localparam ebi_addr_t EBI_TIME_LO      = 19'd9;
    localparam ebi_addr_t EBI_TIME_HI      = 19'd10;

    // control word bits
    localparam int CTRL_RUN_BIT   = 0;
    localparam int CTRL_CLEAR_BIT = 1;

    // pin controllers take units 0 up to the pin count
    localparam unit_t UNIT_COLLECTOR = 8'hF0;

    localparam int CMD_FIFO_DEPTH = 16;

endpackage

`default_nettype wire

// File: design/mecobo_pin_pkg.sv
// pin and sampling definitions
// pin count, pin modes, channel and round types,
// pin and collector register offsets, sample word and sample FIFO depth
`default_nettype none

package mecobo_pin_pkg;

    localparam int NUM_PINS = 4;

    typedef logic [3:0]  channel_t;
    typedef logic [1:0]  pin_mode_t;
    typedef logic [10:0] round_t;

    // channel, pin level, round number from msb down
    typedef logic [15:0] sample_t;

    localparam pin_mode_t PIN_MODE_LOW    = 2'd0;
    localparam pin_mode_t PIN_MODE_HIGH   = 2'd1;
    localparam pin_mode_t PIN_MODE_SQUARE = 2'd2;

    // half period counts sys_clk ticks
    localparam logic [7:0] PIN_REG_MODE        = 8'd0;
    localparam logic [7:0] PIN_REG_HALF_PERIOD = 8'd1;

    // interval of zero turns polling off
    localparam logic [7:0] COL_REG_MASK     = 8'd0;
    localparam logic [7:0] COL_REG_INTERVAL = 8'd1;

    localparam int SAMPLE_FIFO_DEPTH = 32;

endpackage

`default_nettype wire

// File: design/ebi_slave.sv
// host bus slave
// command staging words and command FIFO push,
// global time counter with run flag, status and sample readout
`timescale 1ns/100ps
`default_nettype none

module ebi_slave (
    input  logic                       sys_clk,
    input  logic                       mecobo_reset,
    input  mecobo_bus_pkg::ebi_addr_t  ebi_addr,
    input  mecobo_bus_pkg::ebi_word_t  ebi_data_in,
    input  logic                       ebi_cs,
    input  logic                       ebi_wr,
    input  logic                       ebi_rd,
    output mecobo_bus_pkg::ebi_word_t  ebi_data_out,
    output mecobo_bus_pkg::timestamp_t global_time,
    output mecobo_bus_pkg::command_t   cmd_fifo_din,
    output logic                       cmd_fifo_wr_en,
    input  logic                       cmd_fifo_empty,
    input  logic                       cmd_fifo_full,
    input  mecobo_pin_pkg::sample_t    sample_head,
    input  logic                       sample_empty,
    input  logic                       sample_full,
    input  logic [5:0]                 sample_count,
    output logic                       sample_rd_en
);
    import mecobo_bus_pkg::*;

    ebi_word_t stage [0:3];
    logic      time_run;
    logic      host_wr;
    logic      host_rd;

    assign host_wr = ebi_cs & ebi_wr;
    assign host_rd = ebi_cs & ebi_rd;

    // last word goes straight from the bus into the FIFO
    assign cmd_fifo_din   = {stage[0], stage[1], stage[2], stage[3], ebi_data_in};
    assign cmd_fifo_wr_en = host_wr & (ebi_addr == EBI_CMD_W4);

    // pop only when there is something to pop
    assign sample_rd_en = host_rd & (ebi_addr == EBI_SAMPLE) & ~sample_empty;

    always_ff @(posedge sys_clk) begin
        if (host_wr && ebi_addr < EBI_CMD_W4) begin
            stage[ebi_addr[1:0]] <= ebi_data_in;
        end
    end

    // global time, counts once per tick while running
    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            time_run    <= 1'b0;
            global_time <= '0;
        end else begin
            if (host_wr && ebi_addr == EBI_CTRL) begin
                time_run <= ebi_data_in[CTRL_RUN_BIT];
            end
            if (host_wr && ebi_addr == EBI_CTRL && ebi_data_in[CTRL_CLEAR_BIT]) begin
                global_time <= '0;
            end else if (time_run) begin
                global_time <= global_time + 1'b1;
            end
        end
    end

    // read word is registered and held until the next read
    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            ebi_data_out <= '0;
        end else if (host_rd) begin
            case (ebi_addr)
                EBI_STATUS: begin
                    ebi_data_out <= {12'd0, sample_full, sample_empty,
                                     cmd_fifo_full, cmd_fifo_empty};
                end
                EBI_SAMPLE:       ebi_data_out <= sample_empty ? '0 : sample_head;
                EBI_SAMPLE_COUNT: ebi_data_out <= ebi_word_t'(sample_count);
                EBI_TIME_LO:      ebi_data_out <= global_time[15:0];
                EBI_TIME_HI:      ebi_data_out <= global_time[31:16];
                default:          ebi_data_out <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/command_fifo.sv
// command FIFO
// first-word-fall-through circular buffer of timestamped commands
// with occupancy count and empty and full flags
`timescale 1ns/100ps
`default_nettype none

module command_fifo (
    input  logic                     sys_clk,
    input  logic                     mecobo_reset,
    input  mecobo_bus_pkg::command_t din,
    input  logic                     wr_en,
    input  logic                     rd_en,
    output mecobo_bus_pkg::command_t dout,
    output logic                     empty,
    output logic                     full,
    output logic [4:0]               count
);
    import mecobo_bus_pkg::*;

    localparam int PTR_W = $clog2(CMD_FIFO_DEPTH);

    command_t         mem [0:CMD_FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == '0);
    assign full  = (count == 5'(CMD_FIFO_DEPTH));
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // head is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/scheduler.sv
// command scheduler
// compares the head timestamp with the global time
// and issues due commands onto the command bus
`timescale 1ns/100ps
`default_nettype none

module scheduler (
    input  logic                       sys_clk,
    input  logic                       mecobo_reset,
    input  mecobo_bus_pkg::timestamp_t global_time,
    input  mecobo_bus_pkg::command_t   cmd_fifo_dout,
    input  logic                       cmd_fifo_empty,
    output logic                       cmd_fifo_rd_en,
    output logic                       cmd_bus_en,
    output mecobo_bus_pkg::cmd_addr_t  cmd_bus_addr,
    output mecobo_bus_pkg::cmd_data_t  cmd_bus_data
);
    import mecobo_bus_pkg::*;

    timestamp_t head_time;
    logic       due;

    assign head_time = cmd_fifo_dout[CMD_TS_LSB +: $bits(timestamp_t)];

    // pop cycle blocks a second issue while the next head settles
    assign due = ~cmd_fifo_empty & ~cmd_fifo_rd_en & (global_time >= head_time);

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            cmd_fifo_rd_en <= 1'b0;
            cmd_bus_en     <= 1'b0;
        end else begin
            cmd_fifo_rd_en <= due;
            cmd_bus_en     <= due;
        end
    end

    // bus payload
    always_ff @(posedge sys_clk) begin
        if (due) begin
            cmd_bus_addr <= cmd_fifo_dout[CMD_ADDR_LSB +: $bits(cmd_addr_t)];
            cmd_bus_data <= cmd_fifo_dout[$bits(cmd_data_t)-1:0];
        end
    end

endmodule

`default_nettype wire

// File: design/pin_control.sv
// pin controller
// mode and half period registers on the command bus,
// square wave generator, pin driver and poll answer
`timescale 1ns/100ps
`default_nettype none

module pin_control #(
    parameter int POSITION = 0
) (
    input  logic                      sys_clk,
    input  logic                      mecobo_reset,
    input  logic                      cmd_bus_en,
    input  mecobo_bus_pkg::cmd_addr_t cmd_bus_addr,
    input  mecobo_bus_pkg::cmd_data_t cmd_bus_data,
    input  logic                      poll_en,
    input  mecobo_pin_pkg::channel_t  poll_channel,
    output logic                      sample_bit,
    output logic                      pin
);
    import mecobo_bus_pkg::*;
    import mecobo_pin_pkg::*;

    pin_mode_t mode;
    cmd_data_t half_period;
    cmd_data_t tick;
    cmd_data_t toggle_at;
    logic      square;
    logic      sel;
    logic      mode_wr;

    assign sel     = cmd_bus_en && (cmd_bus_addr[15:8] == unit_t'(POSITION));
    assign mode_wr = sel && (cmd_bus_addr[7:0] == PIN_REG_MODE);

    // zero half period behaves as one
    assign toggle_at = (half_period == '0) ? '0 : half_period - 1'b1;

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            mode        <= PIN_MODE_LOW;
            half_period <= '0;
        end else if (mode_wr) begin
            mode <= pin_mode_t'(cmd_bus_data[1:0]);
        end else if (sel && cmd_bus_addr[7:0] == PIN_REG_HALF_PERIOD) begin
            half_period <= cmd_bus_data;
        end
    end

    // square wave restarts low on every mode write
    always_ff @(posedge sys_clk) begin
        if (mecobo_reset || mode_wr) begin
            tick   <= '0;
            square <= 1'b0;
        end else if (mode == PIN_MODE_SQUARE) begin
            if (tick >= toggle_at) begin
                tick   <= '0;
                square <= ~square;
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    always_comb begin
        case (mode)
            PIN_MODE_HIGH:   pin = 1'b1;
            PIN_MODE_SQUARE: pin = square;
            default:         pin = 1'b0;
        endcase
    end

    // answer only polls of this channel
    assign sample_bit = (poll_en && poll_channel == channel_t'(POSITION)) ? pin : 1'b0;

endmodule

`default_nettype wire

// File: design/sample_collector.sv
// sample collector
// mask and interval registers, interval timer and round counter,
// polling FSM, sample word assembly and sample FIFO
`timescale 1ns/100ps
`default_nettype none

module sample_collector (
    input  logic                      sys_clk,
    input  logic                      mecobo_reset,
    input  logic                      cmd_bus_en,
    input  mecobo_bus_pkg::cmd_addr_t cmd_bus_addr,
    input  mecobo_bus_pkg::cmd_data_t cmd_bus_data,
    output logic                      poll_en,
    output mecobo_pin_pkg::channel_t  poll_channel,
    input  logic                      poll_level,
    input  logic                      sample_rd_en,
    output mecobo_pin_pkg::sample_t   sample_head,
    output logic                      sample_empty,
    output logic                      sample_full,
    output logic [5:0]                sample_count
);
    import mecobo_bus_pkg::*;
    import mecobo_pin_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        POLL,
        PUSH
    } state_t;

    localparam int PTR_W = $clog2(SAMPLE_FIFO_DEPTH);

    state_t              state;
    logic [NUM_PINS-1:0] mask;
    logic [NUM_PINS-1:0] pending;
    logic [NUM_PINS-1:0] pending_next;
    cmd_data_t           interval;
    cmd_data_t           timer;
    round_t              round;
    logic                sel;
    logic                round_start;
    channel_t            poll_ch_q;
    logic                poll_level_q;
    logic                push_q;
    sample_t             fifo_mem [0:SAMPLE_FIFO_DEPTH-1];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic                do_wr;
    logic                do_rd;

    function automatic channel_t lowest_channel(input logic [NUM_PINS-1:0] bits);
        channel_t ch;
        ch = '0;
        for (int i = NUM_PINS - 1; i >= 0; i--) begin
            if (bits[i]) begin
                ch = channel_t'(i);
            end
        end
        return ch;
    endfunction

    assign sel = cmd_bus_en && (cmd_bus_addr[15:8] == UNIT_COLLECTOR);

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            mask     <= '0;
            interval <= '0;
        end else if (sel && cmd_bus_addr[7:0] == COL_REG_MASK) begin
            mask <= cmd_bus_data[NUM_PINS-1:0];
        end else if (sel && cmd_bus_addr[7:0] == COL_REG_INTERVAL) begin
            interval <= cmd_bus_data;
        end
    end

    // interval timer
    assign round_start = (interval != '0) && (timer >= interval - 1'b1);

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset || interval == '0 || round_start) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // one enabled channel per cycle, lowest first
    assign poll_en      = (state == POLL);
    assign poll_channel = lowest_channel(pending);
    assign pending_next = pending & (pending - 1'b1);

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            state   <= IDLE;
            pending <= '0;
            round   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (round_start && mask != '0) begin
                        pending <= mask;
                        state   <= POLL;
                    end
                end
                POLL: begin
                    pending <= pending_next;
                    if (pending_next == '0) begin
                        state <= PUSH;
                    end
                end
                PUSH: begin
                    // advances even when samples were dropped
                    round <= round + 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // poll result, assembled and pushed one cycle later
    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            push_q <= 1'b0;
        end else begin
            push_q <= poll_en;
        end
    end

    always_ff @(posedge sys_clk) begin
        poll_ch_q    <= poll_channel;
        poll_level_q <= poll_level;
    end

    // sample FIFO
    assign sample_empty = (sample_count == '0);
    assign sample_full  = (sample_count == 6'(SAMPLE_FIFO_DEPTH));
    assign do_wr        = push_q & ~sample_full;
    assign do_rd        = sample_rd_en & ~sample_empty;
    assign sample_head  = fifo_mem[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            fifo_mem[wr_ptr] <= {poll_ch_q, poll_level_q, round};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            sample_count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                sample_count <= sample_count + 1'b1;
            end else if (do_rd && !do_wr) begin
                sample_count <= sample_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mecobo_core.sv
// digital core top level
// EBI slave, command FIFO, scheduler, pin controllers
// and sample collector on one command bus
`timescale 1ns/100ps
`default_nettype none

module mecobo_core (
    input  logic                               sys_clk,
    input  logic                               mecobo_reset,
    input  mecobo_bus_pkg::ebi_addr_t          ebi_addr,
    input  mecobo_bus_pkg::ebi_word_t          ebi_data_in,
    output mecobo_bus_pkg::ebi_word_t          ebi_data_out,
    input  logic                               ebi_cs,
    input  logic                               ebi_wr,
    input  logic                               ebi_rd,
    output logic [mecobo_pin_pkg::NUM_PINS-1:0] pins
);
    import mecobo_bus_pkg::*;
    import mecobo_pin_pkg::*;

    timestamp_t          global_time;
    command_t            cmd_fifo_din;
    logic                cmd_fifo_wr_en;
    command_t            cmd_fifo_dout;
    logic                cmd_fifo_empty;
    logic                cmd_fifo_full;
    logic [4:0]          cmd_fifo_count;
    logic                cmd_fifo_rd_en;
    logic                cmd_bus_en;
    cmd_addr_t           cmd_bus_addr;
    cmd_data_t           cmd_bus_data;
    logic                poll_en;
    channel_t            poll_channel;
    logic                poll_level;
    logic [NUM_PINS-1:0] sample_bits;
    sample_t             sample_head;
    logic                sample_empty;
    logic                sample_full;
    logic [5:0]          sample_count;
    logic                sample_rd_en;

    ebi_slave ebi_if (
        .sys_clk        (sys_clk),
        .mecobo_reset   (mecobo_reset),
        .ebi_addr       (ebi_addr),
        .ebi_data_in    (ebi_data_in),
        .ebi_cs         (ebi_cs),
        .ebi_wr         (ebi_wr),
        .ebi_rd         (ebi_rd),
        .ebi_data_out   (ebi_data_out),
        .global_time    (global_time),
        .cmd_fifo_din   (cmd_fifo_din),
        .cmd_fifo_wr_en (cmd_fifo_wr_en),
        .cmd_fifo_empty (cmd_fifo_empty),
        .cmd_fifo_full  (cmd_fifo_full),
        .sample_head    (sample_head),
        .sample_empty   (sample_empty),
        .sample_full    (sample_full),
        .sample_count   (sample_count),
        .sample_rd_en   (sample_rd_en)
    );

    command_fifo cmd_fifo (
        .sys_clk      (sys_clk),
        .mecobo_reset (mecobo_reset),
        .din          (cmd_fifo_din),
        .wr_en        (cmd_fifo_wr_en),
        .rd_en        (cmd_fifo_rd_en),
        .dout         (cmd_fifo_dout),
        .empty        (cmd_fifo_empty),
        .full         (cmd_fifo_full),
        .count        (cmd_fifo_count)
    );

    scheduler sched (
        .sys_clk        (sys_clk),
        .mecobo_reset   (mecobo_reset),
        .global_time    (global_time),
        .cmd_fifo_dout  (cmd_fifo_dout),
        .cmd_fifo_empty (cmd_fifo_empty),
        .cmd_fifo_rd_en (cmd_fifo_rd_en),
        .cmd_bus_en     (cmd_bus_en),
        .cmd_bus_addr   (cmd_bus_addr),
        .cmd_bus_data   (cmd_bus_data)
    );

    // unit number and channel follow the pin index
    for (genvar i = 0; i < NUM_PINS; i++) begin : pin_ctrl
        pin_control #(
            .POSITION (i)
        ) pc (
            .sys_clk      (sys_clk),
            .mecobo_reset (mecobo_reset),
            .cmd_bus_en   (cmd_bus_en),
            .cmd_bus_addr (cmd_bus_addr),
            .cmd_bus_data (cmd_bus_data),
            .poll_en      (poll_en),
            .poll_channel (poll_channel),
            .sample_bit   (sample_bits[i]),
            .pin          (pins[i])
        );
    end

    // only the polled controller drives a one
    assign poll_level = |sample_bits;

    sample_collector collector0 (
        .sys_clk      (sys_clk),
        .mecobo_reset (mecobo_reset),
        .cmd_bus_en   (cmd_bus_en),
        .cmd_bus_addr (cmd_bus_addr),
        .cmd_bus_data (cmd_bus_data),
        .poll_en      (poll_en),
        .poll_channel (poll_channel),
        .poll_level   (poll_level),
        .sample_rd_en (sample_rd_en),
        .sample_head  (sample_head),
        .sample_empty (sample_empty),
        .sample_full  (sample_full),
        .sample_count (sample_count)
    );

endmodule

`default_nettype wire

// File: testbench/mecobo_core_tb.sv
// testbench for the digital core
// clock and reset, EBI read and write tasks, stimulus table,
// compare tasks, timed command, square wave, sampling and full FIFO tests,
// watchdog and summary
`timescale 1ns/100ps
`default_nettype none

module mecobo_core_tb;
    import mecobo_bus_pkg::*;
    import mecobo_pin_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 44990;

    typedef enum {OP_WR, OP_RD, OP_CMD, OP_PINS, OP_IDLE} op_t;

    // OP_CMD keeps the command address in addr, OP_PINS and OP_IDLE a cycle count in value
    typedef struct {
        op_t       op;
        ebi_addr_t addr;
        cmd_data_t value;
        ebi_word_t expected;
    } row_t;

    logic                sys_clk = 1'b0;
    logic                mecobo_reset;
    ebi_addr_t           ebi_addr;
    ebi_word_t           ebi_data_in;
    ebi_word_t           ebi_data_out;
    logic                ebi_cs;
    logic                ebi_wr;
    logic                ebi_rd;
    logic [NUM_PINS-1:0] pins;

    row_t  rows [$];
    logic  table_ready = 1'b0;
    int    errors      = 0;
    int    tests_run   = 0;
    int    tests_failed = 0;
    int    errors_at_start;
    string test_name;

    mecobo_core uut (
        .sys_clk      (sys_clk),
        .mecobo_reset (mecobo_reset),
        .ebi_addr     (ebi_addr),
        .ebi_data_in  (ebi_data_in),
        .ebi_data_out (ebi_data_out),
        .ebi_cs       (ebi_cs),
        .ebi_wr       (ebi_wr),
        .ebi_rd       (ebi_rd),
        .pins         (pins)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_word(input ebi_word_t actual, input ebi_word_t expected,
                              input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s got %h, expected %h", what, actual, expected));
        end
    endtask

    task automatic check_sample(input sample_t actual, input sample_t expected,
                                input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf(
                "%s got ch %0d lvl %0d rnd %0d, expected ch %0d lvl %0d rnd %0d",
                what, actual[15:12], actual[11], actual[10:0],
                expected[15:12], expected[11], expected[10:0]));
        end
    endtask

    task automatic check_pins(input logic [NUM_PINS-1:0] actual,
                              input logic [NUM_PINS-1:0] expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s got %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, test_name,
                     errors - errors_at_start);
        end
    endtask

    // single-cycle strobes, sampled by the DUT at the second edge
    task automatic ebi_write(input ebi_addr_t addr, input ebi_word_t data);
        @(posedge sys_clk);
        ebi_addr    <= addr;
        ebi_data_in <= data;
        ebi_cs      <= 1'b1;
        ebi_wr      <= 1'b1;
        @(posedge sys_clk);
        ebi_cs <= 1'b0;
        ebi_wr <= 1'b0;
    endtask

    task automatic ebi_read(input ebi_addr_t addr, output ebi_word_t data);
        @(posedge sys_clk);
        ebi_addr <= addr;
        ebi_cs   <= 1'b1;
        ebi_rd   <= 1'b1;
        @(posedge sys_clk);
        ebi_cs <= 1'b0;
        ebi_rd <= 1'b0;
        @(negedge sys_clk);
        data = ebi_data_out;
    endtask

    task automatic push_command(input timestamp_t ts, input cmd_addr_t ca, input cmd_data_t cd);
        ebi_write(EBI_CMD_W0, ts[31:16]);
        ebi_write(EBI_CMD_W1, ts[15:0]);
        ebi_write(EBI_CMD_W2, ca);
        ebi_write(EBI_CMD_W3, cd[31:16]);
        ebi_write(EBI_CMD_W4, cd[15:0]);
    endtask

    task automatic add_row(input op_t op, input ebi_addr_t addr, input cmd_data_t value,
                           input ebi_word_t expected);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.value    = value;
        r.expected = expected;
        rows.push_back(r);
    endtask

    task automatic apply_rows(input int first, input int last);
        row_t      r;
        ebi_word_t rd;
        int        waited;
        for (int i = first; i < last; i++) begin
            r = rows[i];
            case (r.op)
                OP_WR:  ebi_write(r.addr, r.value[15:0]);
                OP_RD: begin
                    ebi_read(r.addr, rd);
                    check_word(rd, r.expected,
                               $sformatf("row %0d read of address %0d", i, r.addr));
                end
                OP_CMD: push_command('0, cmd_addr_t'(r.addr), r.value);
                OP_PINS: begin
                    waited = 0;
                    @(negedge sys_clk);
                    while (pins !== r.expected[NUM_PINS-1:0] && waited < int'(r.value)) begin
                        @(negedge sys_clk);
                        waited++;
                    end
                    check_pins(pins, r.expected[NUM_PINS-1:0], $sformatf("row %0d pins", i));
                end
                default: repeat (r.value) @(posedge sys_clk);
            endcase
        end
    endtask

    // cycles from the current level of one pin until it changes
    task automatic measure_edge(input int idx, input int limit, output int n);
        logic prev;
        prev = pins[idx];
        n    = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (pins[idx] === prev && n < limit);
    endtask

    initial begin
        int         wait_ns;
        wait (table_ready);
        wait_ns = rows.size() * 50 * CLK_PERIOD + 20000;
        #(wait_ns);
        $display("watchdog expired after %0d ns, the DUT stopped responding", wait_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int         b1_end;
        int         b2_end;
        int         b5_end;
        int         n;
        int         edges;
        logic       prev;
        timestamp_t t_due;
        timestamp_t t_now;
        cmd_data_t  half;
        ebi_word_t  lo;
        ebi_word_t  hi;
        ebi_word_t  cnt;
        ebi_word_t  w;

        void'($urandom(SEED));
        mecobo_reset <= 1'b1;
        ebi_addr     <= '0;
        ebi_data_in  <= '0;
        ebi_cs       <= 1'b0;
        ebi_wr       <= 1'b0;
        ebi_rd       <= 1'b0;

        // reset state
        add_row(OP_RD, EBI_STATUS, 0, 16'h0005);
        add_row(OP_RD, EBI_TIME_LO, 0, 16'h0000);
        add_row(OP_RD, EBI_SAMPLE_COUNT, 0, 16'h0000);
        add_row(OP_PINS, 0, 1, 16'h0000);
        b1_end = rows.size();
        // immediate commands with time stopped, pin 1 last so its latency is seen
        add_row(OP_CMD, 19'h00200, 0, 0);
        add_row(OP_CMD, 19'h00100, 1, 0);
        add_row(OP_PINS, 0, 4, 16'h0002);
        add_row(OP_RD, EBI_STATUS, 0, 16'h0005);
        add_row(OP_RD, EBI_TIME_LO, 0, 16'h0000);
        b2_end = rows.size();
        // sampling setup, then polling off before the drain
        add_row(OP_CMD, 19'h00000, 1, 0);
        add_row(OP_CMD, 19'h00100, 1, 0);
        add_row(OP_CMD, 19'h00200, 0, 0);
        add_row(OP_CMD, 19'h00300, 0, 0);
        add_row(OP_PINS, 0, 8, 16'h0003);
        add_row(OP_CMD, 19'h0F000, 5, 0);
        add_row(OP_CMD, 19'h0F001, 40, 0);
        add_row(OP_IDLE, 0, 200, 0);
        add_row(OP_CMD, 19'h0F001, 0, 0);
        add_row(OP_IDLE, 0, 10, 0);
        b5_end = rows.size();
        table_ready = 1'b1;

        repeat (3) @(posedge sys_clk);
        mecobo_reset <= 1'b0;

        start_test("reset state");
        apply_rows(0, b1_end);
        finish_test();

        start_test("immediate commands");
        apply_rows(b1_end, b2_end);
        finish_test();

        start_test("timed command");
        ebi_write(EBI_CTRL, 16'h0003);
        t_due = 100 + ($urandom % 200);
        push_command(t_due, 16'h0000, 1);
        n = 0;
        while (pins[0] !== 1'b1 && n < int'(t_due) + 100) begin
            @(negedge sys_clk);
            n++;
        end
        if (pins[0] !== 1'b1) begin
            report_failure("pin 0 never went high after its timestamp");
        end else begin
            ebi_read(EBI_TIME_LO, lo);
            ebi_read(EBI_TIME_HI, hi);
            t_now = {hi, lo};
            if (t_now < t_due || t_now > t_due + 8) begin
                report_mismatch($sformatf("pin 0 rose at time %0d, due at %0d", t_now, t_due));
            end
        end
        finish_test();

        start_test("square wave");
        half = 2 + ($urandom % 19);
        push_command(0, 16'h0301, half);
        push_command(0, 16'h0300, cmd_data_t'(PIN_MODE_SQUARE));
        // first edge only lines up the measurement
        measure_edge(3, 64, n);
        for (int k = 0; k < 4; k++) begin
            measure_edge(3, 64, n);
            check_word(ebi_word_t'(n), half[15:0], $sformatf("half period %0d", k));
        end
        finish_test();

        start_test("sampling");
        apply_rows(b2_end, b5_end);
        ebi_read(EBI_SAMPLE_COUNT, cnt);
        if (cnt == 0 || cnt[0]) begin
            report_failure($sformatf("expected an even nonzero sample count, found %0d", cnt));
        end
        for (int k = 0; k < int'(cnt); k++) begin
            ebi_read(EBI_SAMPLE, w);
            if (k % 2 == 0) begin
                check_sample(w, {4'd0, 1'b1, round_t'(k / 2)}, $sformatf("sample %0d", k));
            end else begin
                check_sample(w, {4'd2, 1'b0, round_t'(k / 2)}, $sformatf("sample %0d", k));
            end
        end
        ebi_read(EBI_STATUS, w);
        check_word(w, 16'h0005, "status after drain");
        finish_test();

        start_test("command FIFO full");
        ebi_write(EBI_CTRL, 16'h0002);
        t_due = 600 + ($urandom % 200);
        // alternate high and low so every applied write is one edge
        for (int k = 0; k < CMD_FIFO_DEPTH + 1; k++) begin
            push_command(t_due + k, 16'h0200, (k % 2 == 0) ? 1 : 0);
        end
        ebi_read(EBI_STATUS, w);
        check_word(w, 16'h0006, "status with full FIFO");
        ebi_write(EBI_CTRL, 16'h0001);
        edges = 0;
        prev  = pins[2];
        repeat (int'(t_due) + 2 * (CMD_FIFO_DEPTH + 1) + 40) begin
            @(negedge sys_clk);
            if (pins[2] !== prev) begin
                edges++;
                prev = pins[2];
            end
        end
        check_word(ebi_word_t'(edges), ebi_word_t'(CMD_FIFO_DEPTH), "pin 2 edge count");
        ebi_read(EBI_STATUS, w);
        check_word(w, 16'h0005, "status after run");
        check_pins(pins, 4'b0011, "final pins");
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
design/mecobo_bus_pkg.sv
design/mecobo_pin_pkg.sv
design/ebi_slave.sv
design/command_fifo.sv
design/scheduler.sv
design/pin_control.sv
design/sample_collector.sv
design/mecobo_core.sv
testbench/mecobo_core_tb.sv

// File: Makefile
SIM := obj_dir/Vmecobo_core_tb

.PHONY: run clean

$(SIM): src.f $(wildcard design/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing -Wno-fatal --top-module mecobo_core_tb -f src.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q 'Simulation finished: PASS'

clean:
	rm -rf obj_dir
